// File: design/commandSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module commandSequencer import sdramPkg::*; #(
	parameter int PowerUpCycles    = 5000,          // clocks with cke low after reset
	parameter int InitRefreshCount = 8,             // auto refreshes during init
	parameter int CasLatency       = 2              // 2 or 3
) (
	input  wire         Clock,
	input  wire         Reset_L,
	input  wire         ReqValid,
	input  wire hostOpT Op,
	input  wire bankT   Bank,
	input  wire rowT    Row,
	input  wire colT    Col,
	input  wire dataT   WriteData,
	input  wire         RefreshDue,
	output logic        ReqReady,
	output logic        Accept,
	output logic        InitDone,
	output logic        RefreshAck,
	output logic        ReadIssued,                  // lines up with the read on the pins
	output logic        Cke,
	output logic        CsL,
	output logic        RasL,
	output logic        CasL,
	output logic        WeL,
	output sdramAddrT   Addr,
	output bankT        Ba,
	output dataT        DqOut,
	output logic        DqOe,
	output logic [1:0]  Dqm                          // {hi, lo} byte masks
);

	localparam int TimerWidth = $clog2(PowerUpCycles + CasLatency + 4);
	localparam int LoopWidth  = $clog2(InitRefreshCount + 2);
	// burst length 1, sequential, cas latency in a6..a4
	localparam sdramAddrT ModeWord = {3'b000, 1'b0, 2'b00, 3'(CasLatency), 1'b0, 3'b000};
	localparam sdramAddrT AllBanks = sdramAddrT'(1 << 10);       // a10 high

	seqStateT              state, stateNext;
	sdramCmdT              cmdNext;
	logic [TimerWidth-1:0] waitCnt, waitNext;                  // shared wait timer
	logic [LoopWidth-1:0]  refLeft, refLeftNext;               // init refreshes still to go
	sdramAddrT             addrNext;
	bankT                  baNext;
	logic [1:0]            dqmNext;
	logic                  ckeNext, dqOeNext, ackNext, issueNext;

	assign ReqReady = (state == StIdle) && !RefreshDue;        // refresh has priority
	assign Accept   = ReqReady && ReqValid;

	//////////////////////////////
	// next state and pin values
	//////////////////////////////
	always_comb begin
		stateNext   = state;
		cmdNext     = Nop;                                   // nop unless a state says so
		ckeNext     = 1'b1;
		addrNext    = '0;
		baNext      = '0;
		dqmNext     = 2'b11;                                 // masked outside an access
		dqOeNext    = 1'b0;
		ackNext     = 1'b0;
		issueNext   = 1'b0;
		refLeftNext = refLeft;
		waitNext    = (waitCnt != '0) ? waitCnt - 1'b1 : '0;
		unique case (state)
			StPowerUp: begin
				cmdNext = Inhibit;
				ckeNext = 1'b0;                              // clock enable held off
				if (waitCnt == '0)
					stateNext = StFirstNop;
			end
			StFirstNop:         stateNext = StInitPrecharge;
			StInitPrecharge: begin
				cmdNext     = PrechargeAll;
				addrNext    = AllBanks;
				refLeftNext = LoopWidth'(InitRefreshCount);
				stateNext   = StInitPrechargeNop;
			end
			StInitPrechargeNop: stateNext = (refLeft != '0) ? StInitRefresh : StModeSet;
			StInitRefresh: begin
				cmdNext     = AutoRefresh;
				refLeftNext = refLeft - 1'b1;
				waitNext    = TimerWidth'(2);                // three nops follow
				stateNext   = StInitRefreshNop;
			end
			StInitRefreshNop: begin
				if (waitCnt == '0)
					stateNext = (refLeft != '0) ? StInitRefresh : StModeSet;
			end
			StModeSet: begin
				cmdNext   = ModeRegisterSet;
				addrNext  = ModeWord;                        // ba stays zero
				waitNext  = TimerWidth'(2);
				stateNext = StModeSetNop;
			end
			StModeSetNop: begin
				if (waitCnt == '0)
					stateNext = StIdle;
			end
			StIdle: begin
				if (RefreshDue)
					stateNext = StRefPrecharge;
				else if (Accept)
					stateNext = StActivate;                  // decoder latches this edge
			end
			StRefPrecharge: begin
				cmdNext   = PrechargeAll;
				addrNext  = AllBanks;
				stateNext = StRefNop;
			end
			StRefNop:           stateNext = StRefresh;
			StRefresh: begin
				cmdNext   = AutoRefresh;
				ackNext   = 1'b1;                            // reloads the interval
				waitNext  = TimerWidth'(2);
				stateNext = StRefreshNop;
			end
			StRefreshNop: begin
				if (waitCnt == '0)
					stateNext = StIdle;
			end
			StActivate: begin
				cmdNext   = Activate;
				addrNext  = Row;
				baNext    = Bank;
				dqmNext   = 2'b00;
				stateNext = StActivateNop;
			end
			StActivateNop: begin
				baNext    = Bank;
				dqmNext   = 2'b00;
				stateNext = (Op == OpWrite) ? StWrite : StRead;
			end
			StWrite: begin
				cmdNext   = Write;
				addrNext  = AllBanks | sdramAddrT'(Col);     // auto precharge
				baNext    = Bank;
				dqmNext   = 2'b00;
				dqOeNext  = 1'b1;                            // data goes out with the command
				waitNext  = TimerWidth'(1);                  // two recovery nops
				stateNext = StWriteRecover;
			end
			StWriteRecover: begin
				dqmNext = 2'b00;
				if (waitCnt == '0)
					stateNext = StIdle;
			end
			StRead: begin
				cmdNext   = Read;
				addrNext  = AllBanks | sdramAddrT'(Col);     // auto precharge
				baNext    = Bank;
				dqmNext   = 2'b00;
				issueNext = 1'b1;
				waitNext  = TimerWidth'(CasLatency);         // cas latency plus one nops
				stateNext = StReadWait;
			end
			StReadWait: begin
				dqmNext = 2'b00;                             // dqm read latency covered
				if (waitCnt == '0)
					stateNext = StIdle;
			end
			default:            stateNext = StPowerUp;
		endcase
	end

	//////////////////////////////
	// state and pin registers
	//////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state                  <= StPowerUp;
			waitCnt                <= TimerWidth'(PowerUpCycles - 1);  // power up wait armed
			refLeft                <= '0;
			Cke                    <= 1'b0;
			{CsL, RasL, CasL, WeL} <= Inhibit;
			Dqm                    <= 2'b11;
			DqOe                   <= 1'b0;
			InitDone               <= 1'b0;
			RefreshAck             <= 1'b0;
			ReadIssued             <= 1'b0;
		end else begin
			state                  <= stateNext;
			waitCnt                <= waitNext;
			refLeft                <= refLeftNext;
			Cke                    <= ckeNext;
			{CsL, RasL, CasL, WeL} <= cmdNext;
			Dqm                    <= dqmNext;
			DqOe                   <= dqOeNext;
			RefreshAck             <= ackNext;
			ReadIssued             <= issueNext;
			if (state == StModeSetNop && waitCnt == '0)
				InitDone <= 1'b1;                            // sticky until reset
		end
	end

	always_ff @(posedge Clock) begin
		Addr <= addrNext;
		Ba   <= baNext;
		if (state == StWrite)
			DqOut <= WriteData;                              // held until the next write
	end

	// refresh scheduler and host only see init done after the mode register set
	assert property (@(posedge Clock) disable iff (!Reset_L)
		({CsL, RasL, CasL, WeL} == Activate) |-> InitDone)
		else $error("activate before init done");

	assert property (@(posedge Clock) disable iff (!Reset_L)
		DqOe |-> ({CsL, RasL, CasL, WeL} == Write))
		else $error("dq driven outside a write command");

endmodule

`default_nettype wire

// File: design/readCapture.sv
`timescale 1ns/1ps
`default_nettype none

module readCapture import sdramPkg::*; #(
	parameter int CasLatency = 2                     // 2 or 3
) (
	input  wire       Clock,
	input  wire       Reset_L,
	input  wire       ReadIssued,                    // high in the read command cycle
	input  wire dataT DqIn,
	output logic      RspValid,                      // one cycle, no back pressure
	output dataT      RspData
);

	logic [CasLatency-1:0] issuePipe;                // one bit per read in flight
	logic                  captureNow;

	assign captureNow = issuePipe[CasLatency-1];     // cas latency after the command

	//////////////////////////////
	// latency pipe
	//////////////////////////////
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			issuePipe <= '0;
			RspValid  <= 1'b0;
		end else begin
			issuePipe <= {issuePipe[CasLatency-2:0], ReadIssued};   // shift toward the msb
			RspValid  <= captureNow;                     // data is on RspData now
		end
	end

	// sample dq at the edge that ends the latency
	always_ff @(posedge Clock) begin
		if (captureNow)
			RspData <= DqIn;
	end

	// reads are spaced wider than the latency, so pulses never merge
	assert property (@(posedge Clock) disable iff (!Reset_L)
		RspValid |=> !RspValid)
		else $error("read response held two cycles");

endmodule

`default_nettype wire

// File: design/refreshScheduler.sv
`timescale 1ns/1ps
`default_nettype none

module refreshScheduler #(
	parameter int RefreshInterval = 375              // clocks between refresh requests
) (
	input  wire  Clock,
	input  wire  Reset_L,
	input  wire  InitDone,                           // level, high once init finished
	input  wire  RefreshAck,                         // one cycle, with the auto refresh
	output logic RefreshDue                          // held until acked
);

	localparam int CountWidth = $clog2(RefreshInterval + 1);

	logic [CountWidth-1:0] count;                    // down counter to next refresh
	logic                  initDoneDly;              // also arms the due flag

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			initDoneDly <= 1'b0;
			count       <= '0;
			RefreshDue  <= 1'b0;
		end else begin
			initDoneDly <= InitDone;
			if ((InitDone && !initDoneDly) || RefreshAck)
				count <= CountWidth'(RefreshInterval);   // start or restart interval
			else if (count != '0)
				count <= count - 1'b1;                   // parks at zero
			if (RefreshAck)
				RefreshDue <= 1'b0;                      // ack wins over a new due
			else if (initDoneDly && count == '0)
				RefreshDue <= 1'b1;
		end
	end

	// the sequencer is the only one allowed to clear a pending refresh
	assert property (@(posedge Clock) disable iff (!Reset_L)
		$fell(RefreshDue) |-> $past(RefreshAck))
		else $error("refresh due dropped without an ack");

endmodule

`default_nettype wire

// File: design/requestDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module requestDecoder import sdramPkg::*; (
	input  wire           Clock,
	input  wire           Reset_L,
	input  wire           Accept,                  // one cycle, request taken this edge
	input  wire hostOpT   ReqOp,
	input  wire hostAddrT ReqAddr,
	input  wire dataT     ReqData,
	output hostOpT        Op,                      // held for the whole access
	output bankT          Bank,
	output rowT           Row,
	output colT           Col,
	output dataT          WriteData
);

	// opcode steers the sequencer, so it comes out of reset known
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			Op <= OpRead;
		end else if (Accept) begin
			Op <= ReqOp;
		end
	end

	// address split, bank on top then row then column
	always_ff @(posedge Clock) begin
		if (Accept) begin
			Bank      <= ReqAddr[ColWidth+RowWidth +: BankWidth];   // top two bits
			Row       <= ReqAddr[ColWidth +: RowWidth];             // middle thirteen
			Col       <= ReqAddr[ColWidth-1:0];                     // low ten
			WriteData <= ReqData;                                   // unused on reads
		end
	end

endmodule

`default_nettype wire

// File: design/sdramController.sv
`timescale 1ns/1ps
`default_nettype none

module sdramController import sdramPkg::*; #(
	parameter int PowerUpCycles    = 5000,          // about 100 us at 50 MHz
	parameter int InitRefreshCount = 8,
	parameter int RefreshInterval  = 375,           // 7.5 us at 50 MHz
	parameter int CasLatency       = 2
) (
	input  wire           Clock,
	input  wire           Reset_L,
	// host request and read response
	input  wire           ReqValid,
	output logic          ReqReady,
	input  wire hostOpT   ReqOp,
	input  wire hostAddrT ReqAddr,
	input  wire dataT     ReqData,
	output logic          RspValid,
	output dataT          RspData,
	// sdram pins
	output logic          Cke,
	output logic          CsL,
	output logic          RasL,
	output logic          CasL,
	output logic          WeL,
	output sdramAddrT     Addr,
	output bankT          Ba,
	output dataT          DqOut,
	output logic          DqOe,
	input  wire dataT     DqIn,
	output logic [1:0]    Dqm
);

	logic   accept, initDone, refreshDue, refreshAck, readIssued;
	hostOpT accOp;                                  // latched request fields
	bankT   accBank;
	rowT    accRow;
	colT    accCol;
	dataT   accData;

	requestDecoder i_requestDecoder (
		.Clock(Clock), .Reset_L(Reset_L), .Accept(accept),
		.ReqOp(ReqOp), .ReqAddr(ReqAddr), .ReqData(ReqData),
		.Op(accOp), .Bank(accBank), .Row(accRow), .Col(accCol), .WriteData(accData)
	);

	refreshScheduler #(.RefreshInterval(RefreshInterval)) i_refreshScheduler (
		.Clock(Clock), .Reset_L(Reset_L), .InitDone(initDone),
		.RefreshAck(refreshAck), .RefreshDue(refreshDue)
	);

	commandSequencer #(
		.PowerUpCycles(PowerUpCycles), .InitRefreshCount(InitRefreshCount),
		.CasLatency(CasLatency)
	) i_commandSequencer (
		.Clock(Clock), .Reset_L(Reset_L), .ReqValid(ReqValid),
		.Op(accOp), .Bank(accBank), .Row(accRow), .Col(accCol), .WriteData(accData),
		.RefreshDue(refreshDue), .ReqReady(ReqReady), .Accept(accept),
		.InitDone(initDone), .RefreshAck(refreshAck), .ReadIssued(readIssued),
		.Cke(Cke), .CsL(CsL), .RasL(RasL), .CasL(CasL), .WeL(WeL),
		.Addr(Addr), .Ba(Ba), .DqOut(DqOut), .DqOe(DqOe), .Dqm(Dqm)
	);

	readCapture #(.CasLatency(CasLatency)) i_readCapture (
		.Clock(Clock), .Reset_L(Reset_L), .ReadIssued(readIssued),
		.DqIn(DqIn), .RspValid(RspValid), .RspData(RspData)
	);

endmodule

`default_nettype wire

// File: design/sdramPkg.sv
`default_nettype none

package sdramPkg;

	//////////////////////////////
	// field widths
	//////////////////////////////
	localparam int DataWidth      = 16;                       // dq width
	localparam int BankWidth      = 2;                        // ba pins
	localparam int RowWidth       = 13;                       // row address bits
	localparam int ColWidth       = 10;                       // column address bits
	localparam int SdramAddrWidth = 13;                       // a12..a0
	localparam int HostAddrWidth  = BankWidth + RowWidth + ColWidth; // 25 bit word address

	typedef logic [DataWidth-1:0]      dataT;                 // one dq word
	typedef logic [BankWidth-1:0]      bankT;
	typedef logic [RowWidth-1:0]       rowT;
	typedef logic [ColWidth-1:0]       colT;
	typedef logic [HostAddrWidth-1:0]  hostAddrT;             // {bank, row, col}
	typedef logic [SdramAddrWidth-1:0] sdramAddrT;

	//////////////////////////////
	// commands and opcodes
	//////////////////////////////
	// {cs, ras, cas, we}, all active low
	typedef enum logic [3:0] {
		Inhibit         = 4'b1111,                            // cs high, chip ignores the rest
		Nop             = 4'b0111,
		Activate        = 4'b0011,                            // opens row on ba
		Read            = 4'b0101,                            // a10 high gives auto precharge
		Write           = 4'b0100,                            // a10 high gives auto precharge
		PrechargeAll    = 4'b0010,                            // a10 high selects all banks
		AutoRefresh     = 4'b0001,
		ModeRegisterSet = 4'b0000                             // mode word on the address pins
	} sdramCmdT;

	typedef enum logic {
		OpRead  = 1'b0,
		OpWrite = 1'b1
	} hostOpT;

	typedef enum logic [4:0] {
		StPowerUp, StFirstNop,                                 // power up wait
		StInitPrecharge, StInitPrechargeNop,                   // init precharge
		StInitRefresh, StInitRefreshNop,                       // init refresh loop
		StModeSet, StModeSetNop,                               // mode register
		StIdle,
		StRefPrecharge, StRefNop, StRefresh, StRefreshNop,     // periodic refresh
		StActivate, StActivateNop,                             // row open
		StWrite, StWriteRecover,
		StRead, StReadWait
	} seqStateT;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module tbSdramController \
		-f sdramController.f -o simv \
	&& ./obj_dir/simv \
	|| { echo "simulation did not complete successfully"; exit 1; }

// File: sdramController.f
design/sdramPkg.sv
design/requestDecoder.sv
design/refreshScheduler.sv
design/commandSequencer.sv
design/readCapture.sv
design/sdramController.sv
testbench/sdramModel.sv
testbench/tbSdramController.sv

// File: testbench/sdramModel.sv
`timescale 1ns/1ps
`default_nettype none

module sdramModel import sdramPkg::*; #(
	parameter int PowerUpCycles   = 5000,          // minimum clocks with cke low
	parameter int RefreshInterval = 375
) (
	input  wire            Clock,
	input  wire            Reset_L,
	input  wire            Cke,
	input  wire            CsL,
	input  wire            RasL,
	input  wire            CasL,
	input  wire            WeL,
	input  wire sdramAddrT Addr,
	input  wire bankT      Ba,
	input  wire dataT      DqOut,
	input  wire            DqOe,
	input  wire [1:0]      Dqm,
	output dataT           DqIn,
	output logic           Violation                // sticky, seen by the testbench
);

	sdramCmdT cmd;
	dataT     mem [hostAddrT];                      // stored words, {bank, row, col}
	logic     bankOpen [1<<BankWidth];
	rowT      openRow [1<<BankWidth];
	int       ckeLowCycles, casLat, sinceRefresh, gapLimit, rdCnt;
	logic     ckeSeen, prechargeSeen, modeSet;
	dataT     rdWord;                               // word waiting for its latency

	assign cmd = sdramCmdT'({CsL, RasL, CasL, WeL});

	function automatic hostAddrT wordKey(bankT b, rowT r, colT c);
		return {b, r, c};
	endfunction

	function automatic dataT storedWord(hostAddrT key);
		return mem.exists(key) ? mem[key] : '0;     // never written reads as zero
	endfunction

	task automatic reportViolation(string what);
		$display("SDRAM model: %s at %0t ns", what, $time);
		Violation <= 1'b1;
	endtask

	//////////////////////////////
	// command decode and checks
	//////////////////////////////
	always @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			DqIn          <= '0;
			Violation     <= 1'b0;
			ckeLowCycles  <= 0;
			ckeSeen       <= 1'b0;
			prechargeSeen <= 1'b0;
			modeSet       <= 1'b0;
			casLat        <= 0;
			sinceRefresh  <= 0;
			gapLimit      <= 0;
			rdCnt         <= 0;
			rdWord        <= '0;
			for (int b = 0; b < (1<<BankWidth); b++) begin
				bankOpen[b] <= 1'b0;
				openRow[b]  <= '0;
			end
		end else begin
			if (rdCnt == 1)
				DqIn <= rdWord;                         // valid at the cas latency edge
			if (rdCnt != 0)
				rdCnt <= rdCnt - 1;
			if (modeSet) begin
				sinceRefresh <= sinceRefresh + 1;
				if (sinceRefresh > gapLimit)
					reportViolation("refresh overdue");
			end
			if (!Cke) begin
				ckeLowCycles <= ckeLowCycles + 1;
				if (ckeSeen)
					reportViolation("clock enable dropped after power up");
				if (cmd != Inhibit && cmd != Nop)
					reportViolation("command issued while clock enable low");
			end else begin
				if (!ckeSeen && ckeLowCycles < PowerUpCycles)
					reportViolation("power-up wait too short");
				ckeSeen <= 1'b1;
				case (cmd)
					PrechargeAll: begin
						if (!Addr[10])
							reportViolation("precharge without the all-banks bit");
						for (int b = 0; b < (1<<BankWidth); b++)
							bankOpen[b] <= 1'b0;
						prechargeSeen <= 1'b1;
					end
					AutoRefresh: begin
						if (!prechargeSeen)
							reportViolation("refresh before the first precharge");
						for (int b = 0; b < (1<<BankWidth); b++)
							if (bankOpen[b])
								reportViolation("refresh with a bank open");
						if (modeSet) begin
							sinceRefresh <= 0;
							gapLimit     <= RefreshInterval + 18;   // worst access plus refresh
						end
					end
					ModeRegisterSet: begin
						if (Addr[2:0] != 3'b000)
							reportViolation("burst length other than one");
						if (Addr[6:4] != 3'd2 && Addr[6:4] != 3'd3)
							reportViolation("unsupported CAS latency");
						casLat       <= int'(Addr[6:4]);
						modeSet      <= 1'b1;
						sinceRefresh <= 0;
						// first interval also spans the mode wait and the scheduler start
						gapLimit     <= RefreshInterval + 30;
					end
					Activate: begin
						if (!modeSet)
							reportViolation("activate before mode register set");
						if (bankOpen[Ba])
							reportViolation("activate on an open bank");
						bankOpen[Ba] <= 1'b1;
						openRow[Ba]  <= Addr[RowWidth-1:0];
					end
					Write: begin
						if (!bankOpen[Ba])
							reportViolation("write to a closed bank");
						if (!DqOe)
							reportViolation("write without data driven");
						if (Dqm != 2'b00)
							reportViolation("write with bytes masked");
						mem[wordKey(Ba, openRow[Ba], Addr[ColWidth-1:0])] = DqOut;
						if (Addr[10])
							bankOpen[Ba] <= 1'b0;               // auto precharge
					end
					Read: begin
						if (!bankOpen[Ba])
							reportViolation("read from a closed bank");
						if (Dqm != 2'b00)
							reportViolation("read with bytes masked");
						if (rdCnt != 0)
							reportViolation("read while a read is in flight");
						rdWord <= storedWord(wordKey(Ba, openRow[Ba], Addr[ColWidth-1:0]));
						rdCnt  <= casLat - 1;
						if (Addr[10])
							bankOpen[Ba] <= 1'b0;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tbSdramController.sv
`timescale 1ns/1ps
`default_nettype none

module tbSdramController import sdramPkg::*; ();

	localparam int PowerUpCycles    = 40;
	localparam int InitRefreshCount = 4;
	localparam int RefreshInterval  = 120;
	localparam int CasLatency       = 2;
	localparam int ClockPeriod      = 8;            // ns
	localparam int NumRandom        = 200;
	localparam int WatchdogCycles   = 16 + PowerUpCycles + 50 + 20 * (NumRandom + 2) + 2000;
	localparam int ResponseWait     = CasLatency + 12;   // acceptance to last response, generous
	localparam logic [31:0] Seed    = 32'h21e0_be60;

	logic      Clock, Reset_L, ReqValid, ReqReady, RspValid;
	hostOpT    ReqOp;
	hostAddrT  ReqAddr;
	dataT      ReqData, RspData, DqOut, DqIn;
	logic      Cke, CsL, RasL, CasL, WeL, DqOe, modelViolation;
	sdramAddrT Addr;
	bankT      Ba;
	logic [1:0] Dqm;
	sdramCmdT  busCmd;

	dataT      shadow [hostAddrT];                  // last word written per address
	dataT      expectQ[$];                          // reads waiting for a response
	int        readCmdCycle[$];                     // cycle of each read on the bus
	hostAddrT  writtenAddrs[$];
	sdramCmdT  initCmds[$];                         // commands before ready first rises
	string     testName = "reset";
	int        cycle = 0;
	int        readCount = 0;
	int        rspCount = 0;
	int        loadRefreshes = 0;
	logic      readySeen = 1'b0;
	logic      loadPhase = 1'b0;

	assign busCmd = sdramCmdT'({CsL, RasL, CasL, WeL});

	sdramController #(
		.PowerUpCycles(PowerUpCycles), .InitRefreshCount(InitRefreshCount),
		.RefreshInterval(RefreshInterval), .CasLatency(CasLatency)
	) i_sdramController (
		.Clock(Clock), .Reset_L(Reset_L), .ReqValid(ReqValid), .ReqReady(ReqReady),
		.ReqOp(ReqOp), .ReqAddr(ReqAddr), .ReqData(ReqData),
		.RspValid(RspValid), .RspData(RspData),
		.Cke(Cke), .CsL(CsL), .RasL(RasL), .CasL(CasL), .WeL(WeL),
		.Addr(Addr), .Ba(Ba), .DqOut(DqOut), .DqOe(DqOe), .DqIn(DqIn), .Dqm(Dqm)
	);

	sdramModel #(.PowerUpCycles(PowerUpCycles), .RefreshInterval(RefreshInterval)) i_sdramModel (
		.Clock(Clock), .Reset_L(Reset_L), .Cke(Cke), .CsL(CsL), .RasL(RasL),
		.CasL(CasL), .WeL(WeL), .Addr(Addr), .Ba(Ba), .DqOut(DqOut), .DqOe(DqOe),
		.Dqm(Dqm), .DqIn(DqIn), .Violation(modelViolation)
	);

	always #(ClockPeriod / 2) Clock = ~Clock;
	always @(posedge Clock) cycle <= cycle + 1;    // read at the falling edge only

	//////////////////////////////
	// reference and compare tasks
	//////////////////////////////
	function automatic dataT expectedData(hostAddrT addr);
		return shadow.exists(addr) ? shadow[addr] : '0;
	endfunction

	task automatic failRun();
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic checkData(string name, dataT expected, dataT actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			failRun();
		end
	endtask

	task automatic checkCmd(string name, sdramCmdT expected, sdramCmdT actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %s (%b) actual %s (%b)", name,
				expected.name(), expected, actual.name(), actual);
			failRun();
		end
	endtask

	task automatic checkCount(string name, int expected, int actual);
		if (actual != expected) begin
			$display("ERROR %s expected %0d actual %0d", name, expected, actual);
			failRun();
		end
	endtask

	// called at a falling edge; returns one falling edge after acceptance
	task automatic issueRequest(hostOpT op, hostAddrT addr, dataT data);
		ReqValid = 1'b1;
		ReqOp    = op;
		ReqAddr  = addr;
		ReqData  = data;
		while (!ReqReady)
			@(negedge Clock);
		if (op == OpWrite) begin                   // next rising edge takes it
			shadow[addr] = data;
			writtenAddrs.push_back(addr);
		end else begin
			expectQ.push_back(expectedData(addr));
			readCount++;
		end
		@(negedge Clock);
		ReqValid = 1'b0;
	endtask

	// gives up once the last accepted read is overdue
	task automatic waitForResponses();
		int waited;
		waited = 0;
		while (expectQ.size() != 0 && waited < ResponseWait) begin
			@(negedge Clock);
			waited++;
		end
	endtask

	//////////////////////////////
	// bus monitor and compare
	//////////////////////////////
	always @(negedge Clock) begin
		if (modelViolation) begin
			$display("the SDRAM model reported a protocol violation");
			failRun();
		end else if (Reset_L) begin
			if (!readySeen) begin
				if (busCmd != Nop && busCmd != Inhibit)
					initCmds.push_back(busCmd);     // init order check
				readySeen = ReqReady;
			end
			if (busCmd == Read)
				readCmdCycle.push_back(cycle);
			if (DqOe)
				checkCmd("dq drive window", Write, busCmd);
			if (busCmd == AutoRefresh && loadPhase)
				loadRefreshes++;
		end
	end

	always @(negedge Clock) begin
		if (Reset_L && RspValid) begin
			if (expectQ.size() == 0) begin
				$display("read response arrived with no read outstanding");
				failRun();
			end else begin
				checkData(testName, expectQ.pop_front(), RspData);
				checkCount("read latency", CasLatency + 1, cycle - readCmdCycle.pop_front());
				rspCount++;
			end
		end
	end

	initial begin
		#(WatchdogCycles * ClockPeriod);
		$display("timeout: the requests did not finish within %0d cycles", WatchdogCycles);
		failRun();
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial begin
		hostOpT   op;
		hostAddrT addr;
		int       loadStart;
		int       minRefreshes;
		void'($urandom(Seed));
		Clock    = 1'b0;
		Reset_L  = 1'b0;
		ReqValid = 1'b0;
		ReqOp    = OpRead;
		ReqAddr  = '0;
		ReqData  = '0;
		repeat (16) @(negedge Clock);
		checkCount("cke in reset", 0, int'(Cke));
		checkCount("ready in reset", 0, int'(ReqReady));
		checkCount("response in reset", 0, int'(RspValid));
		checkCmd("command in reset", Inhibit, busCmd);
		Reset_L = 1'b1;

		testName = "initialization";
		while (!ReqReady)
			@(negedge Clock);
		checkCount("init command count", InitRefreshCount + 2, initCmds.size());
		checkCmd("init precharge", PrechargeAll, initCmds[0]);
		for (int i = 1; i <= InitRefreshCount; i++)
			checkCmd("init refresh", AutoRefresh, initCmds[i]);
		checkCmd("init mode set", ModeRegisterSet, initCmds[InitRefreshCount + 1]);

		testName = "write then read back";
		issueRequest(OpWrite, hostAddrT'(25'h15a_3c7), dataT'(16'hbeef));
		issueRequest(OpRead, hostAddrT'(25'h15a_3c7), '0);
		waitForResponses();
		checkCount("readback responses", 1, rspCount);

		testName  = "random traffic";
		loadPhase = 1'b1;
		loadStart = cycle;
		for (int i = 0; i < NumRandom; i++) begin
			op = hostOpT'($urandom_range(1));
			if (op == OpRead && writtenAddrs.size() != 0 && $urandom_range(3) != 0)
				addr = writtenAddrs[$urandom_range(writtenAddrs.size() - 1)];
			else
				addr = hostAddrT'($urandom);          // any bank, row and column
			issueRequest(op, addr, dataT'($urandom));
		end
		waitForResponses();
		loadPhase    = 1'b0;
		minRefreshes = (cycle - loadStart) / (RefreshInterval + 18);
		if (loadRefreshes < minRefreshes) begin
			$display("refresh stalled under load: %0d refreshes in %0d cycles",
				loadRefreshes, cycle - loadStart);
			failRun();
		end
		checkCount("read responses", readCount, rspCount);
		checkCount("reads left without response", 0, readCmdCycle.size());
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
